/* hw/ram_pkg.sv */
// Flop RAM package with tile geometry, vector types and request structs
package ram_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------

  // Whole RAM
  localparam int depth = 24;
  localparam int width = 32;
  localparam int word_width = 8;
  localparam int num_words = width / word_width;

  // Tile grid, 2 rows along the address and 2 columns along the data
  localparam int depth_tiles = 2;
  localparam int width_tiles = 2;
  localparam int tile_depth = depth / depth_tiles;
  localparam int tile_width = width / width_tiles;
  localparam int tile_num_words = num_words / width_tiles;

  // Address widths follow from the entry counts
  localparam int addr_width = $clog2(depth);
  localparam int tile_addr_width = $clog2(tile_depth);

  // --------------------------------------------------
  // Vector types
  // --------------------------------------------------
  typedef logic [addr_width-1:0] addr_t;
  typedef logic [tile_addr_width-1:0] tile_addr_t;
  typedef logic [width-1:0] data_t;
  typedef logic [num_words-1:0] word_en_t;
  typedef logic [tile_width-1:0] tile_data_t;
  typedef logic [tile_num_words-1:0] tile_word_en_t;

  // --------------------------------------------------
  // Requests
  // --------------------------------------------------

  // Write request from the outside, 42 bits
  typedef struct packed {
    logic valid;
    addr_t addr;
    data_t data;
    word_en_t word_en;
  } wr_req_t;

  // Read request from the outside, 6 bits
  typedef struct packed {
    logic valid;
    addr_t addr;
  } rd_req_t;

  // Write request for one depth row, full entry still attached
  typedef struct packed {
    logic valid;
    tile_addr_t addr;
    data_t data;
    word_en_t word_en;
  } tile_wr_t;

  // Read request for one depth row
  typedef struct packed {
    logic valid;
    tile_addr_t addr;
  } tile_rd_t;

endpackage

/* hw/ram_addr_decoder.sv */
// Address decode of write and read requests into pipelined per-row tile requests
module ram_addr_decoder #(
  parameter int addr_stages = 1
) (
  input  logic clk,
  input  logic rst,
  input  ram_pkg::wr_req_t wr,
  input  ram_pkg::rd_req_t rd,
  output ram_pkg::tile_wr_t [ram_pkg::depth_tiles-1:0] tile_wr,
  output ram_pkg::tile_rd_t [ram_pkg::depth_tiles-1:0] tile_rd
);

  // Decoded requests, before any pipeline stage
  ram_pkg::tile_wr_t [ram_pkg::depth_tiles-1:0] wr_dec;
  ram_pkg::tile_rd_t [ram_pkg::depth_tiles-1:0] rd_dec;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  for (genvar r = 0; r < ram_pkg::depth_tiles; r++) begin : gen_decode
    // Address window owned by this depth row
    localparam ram_pkg::addr_t base = ram_pkg::addr_t'(r * ram_pkg::tile_depth);
    localparam ram_pkg::addr_t limit = ram_pkg::addr_t'((r + 1) * ram_pkg::tile_depth);

    logic wr_hit;
    logic rd_hit;

    assign wr_hit = (wr.addr >= base) && (wr.addr < limit);
    assign rd_hit = (rd.addr >= base) && (rd.addr < limit);

    // Local address is the offset from the row base
    assign wr_dec[r] = '{
      valid: wr.valid && wr_hit,
      addr: ram_pkg::tile_addr_t'(wr.addr - base),
      data: wr.data,
      word_en: wr.word_en
    };
    assign rd_dec[r] = '{
      valid: rd.valid && rd_hit,
      addr: ram_pkg::tile_addr_t'(rd.addr - base)
    };
  end

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------
  if (addr_stages == 0) begin : gen_no_stages
    // Pure combinational decode
    assign tile_wr = wr_dec;
    assign tile_rd = rd_dec;
  end else begin : gen_stages
    ram_pkg::tile_wr_t [ram_pkg::depth_tiles-1:0] wr_q [addr_stages];
    ram_pkg::tile_rd_t [ram_pkg::depth_tiles-1:0] rd_q [addr_stages];

    always_ff @(posedge clk) begin
      wr_q[0] <= wr_dec;
      rd_q[0] <= rd_dec;
      for (int s = 1; s < addr_stages; s++) begin
        wr_q[s] <= wr_q[s-1];
        rd_q[s] <= rd_q[s-1];
      end
      // Only the valid bits are cleared, payload keeps flowing
      if (rst) begin
        for (int s = 0; s < addr_stages; s++) begin
          for (int r = 0; r < ram_pkg::depth_tiles; r++) begin
            wr_q[s][r].valid <= 1'b0;
            rd_q[s][r].valid <= 1'b0;
          end
        end
      end
    end

    assign tile_wr = wr_q[addr_stages-1];
    assign tile_rd = rd_q[addr_stages-1];
  end

  // Requests must stay inside the RAM
  wr_addr_in_range_a: assert property (@(posedge clk) disable iff (rst)
    wr.valid |-> (wr.addr < ram_pkg::depth));
  rd_addr_in_range_a: assert property (@(posedge clk) disable iff (rst)
    rd.valid |-> (rd.addr < ram_pkg::depth));

endmodule

/* hw/ram_flops_tile.sv */
// Storage tile in flops with word-enabled writes and a combinational read
module ram_flops_tile (
  input  logic clk,
  input  ram_pkg::tile_wr_t wr,
  input  ram_pkg::tile_data_t wr_data,
  input  ram_pkg::tile_word_en_t wr_word_en,
  input  ram_pkg::tile_rd_t rd,
  output logic rd_valid,
  output ram_pkg::tile_data_t rd_data
);

  // Storage array, contents undefined until written
  ram_pkg::tile_data_t mem [ram_pkg::tile_depth];

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------

  // Each enabled word lands on the edge where the request is seen
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      for (int w = 0; w < ram_pkg::tile_num_words; w++) begin
        if (wr_word_en[w]) begin
          mem[wr.addr][w*ram_pkg::word_width +: ram_pkg::word_width] <=
            wr_data[w*ram_pkg::word_width +: ram_pkg::word_width];
        end
      end
    end
  end

  // --------------------------------------------------
  // Read side
  // --------------------------------------------------

  // Same-cycle read of a written entry sees the old value
  assign rd_valid = rd.valid;
  assign rd_data = mem[rd.addr];

  // Local addresses from the decoder fit the tile
  tile_wr_addr_in_range_a: assert property (@(posedge clk)
    wr.valid |-> (wr.addr < ram_pkg::tile_depth));
  tile_rd_addr_in_range_a: assert property (@(posedge clk)
    rd.valid |-> (rd.addr < ram_pkg::tile_depth));

endmodule

/* hw/ram_rd_data_pipe.sv */
// Read data merge across the tile grid and registered output pipeline
module ram_rd_data_pipe #(
  parameter int rd_stages = 1
) (
  input  logic clk,
  input  logic rst,
  input  logic [ram_pkg::depth_tiles-1:0][ram_pkg::width_tiles-1:0] tile_valid,
  input  ram_pkg::tile_data_t [ram_pkg::depth_tiles-1:0][ram_pkg::width_tiles-1:0] tile_data,
  output logic rd_data_valid,
  output ram_pkg::data_t rd_data
);

  // One valid per depth row
  logic [ram_pkg::depth_tiles-1:0] row_valid;
  // Merged column data, column 0 in the low bits
  ram_pkg::tile_data_t [ram_pkg::width_tiles-1:0] col_data;
  logic merged_valid;

  // --------------------------------------------------
  // Row select and column join
  // --------------------------------------------------
  for (genvar r = 0; r < ram_pkg::depth_tiles; r++) begin : gen_row_valid
    assign row_valid[r] = |tile_valid[r];
  end

  always_comb begin
    col_data = '0;
    for (int r = 0; r < ram_pkg::depth_tiles; r++) begin
      for (int c = 0; c < ram_pkg::width_tiles; c++) begin
        // Idle rows contribute zeros
        if (tile_valid[r][c]) begin
          col_data[c] = col_data[c] | tile_data[r][c];
        end
      end
    end
  end

  assign merged_valid = |row_valid;

  // --------------------------------------------------
  // Output stages
  // --------------------------------------------------
  if (rd_stages == 0) begin : gen_no_stages
    assign rd_data_valid = merged_valid;
    assign rd_data = ram_pkg::data_t'(col_data);
  end else begin : gen_stages
    logic valid_q [rd_stages];
    ram_pkg::data_t data_q [rd_stages];

    // Valid shift register
    always_ff @(posedge clk) begin
      if (rst) begin
        for (int s = 0; s < rd_stages; s++) begin
          valid_q[s] <= 1'b0;
        end
      end else begin
        valid_q[0] <= merged_valid;
        for (int s = 1; s < rd_stages; s++) begin
          valid_q[s] <= valid_q[s-1];
        end
      end
    end

    // Data follows without reset
    always_ff @(posedge clk) begin
      data_q[0] <= ram_pkg::data_t'(col_data);
      for (int s = 1; s < rd_stages; s++) begin
        data_q[s] <= data_q[s-1];
      end
    end

    assign rd_data_valid = valid_q[rd_stages-1];
    assign rd_data = data_q[rd_stages-1];
  end

  // The decoder routes each read to a single row
  one_row_valid_a: assert property (@(posedge clk) disable iff (rst)
    $onehot0(row_valid));

endmodule

/* hw/ram_flops.sv */
// Flop RAM top with address decode, 2x2 tile grid and read data pipeline
module ram_flops #(
  parameter int addr_stages = 1,
  parameter int rd_stages = 1
) (
  input  logic clk,
  input  logic rst,
  input  ram_pkg::wr_req_t wr,
  input  ram_pkg::rd_req_t rd,
  output logic rd_data_valid,
  output ram_pkg::data_t rd_data
);

  // Fixed cycles from rd.valid to rd_data_valid
  localparam int rd_latency = addr_stages + rd_stages;

  // Decoded requests per depth row
  ram_pkg::tile_wr_t [ram_pkg::depth_tiles-1:0] tile_wr;
  ram_pkg::tile_rd_t [ram_pkg::depth_tiles-1:0] tile_rd;

  // Tile read outputs by row and column
  logic [ram_pkg::depth_tiles-1:0][ram_pkg::width_tiles-1:0] tile_rd_valid;
  ram_pkg::tile_data_t [ram_pkg::depth_tiles-1:0][ram_pkg::width_tiles-1:0] tile_rd_data;

  ram_addr_decoder #(
    .addr_stages(addr_stages)
  ) u_ram_addr_decoder (
    .clk(clk),
    .rst(rst),
    .wr(wr),
    .rd(rd),
    .tile_wr(tile_wr),
    .tile_rd(tile_rd)
  );

  // --------------------------------------------------
  // Tile grid
  // --------------------------------------------------
  for (genvar r = 0; r < ram_pkg::depth_tiles; r++) begin : gen_row
    for (genvar c = 0; c < ram_pkg::width_tiles; c++) begin : gen_col
      // Column c owns its slice of data and enables
      ram_flops_tile u_ram_flops_tile (
        .clk(clk),
        .wr(tile_wr[r]),
        .wr_data(tile_wr[r].data[c*ram_pkg::tile_width +: ram_pkg::tile_width]),
        .wr_word_en(tile_wr[r].word_en[c*ram_pkg::tile_num_words +: ram_pkg::tile_num_words]),
        .rd(tile_rd[r]),
        .rd_valid(tile_rd_valid[r][c]),
        .rd_data(tile_rd_data[r][c])
      );
    end
  end

  ram_rd_data_pipe #(
    .rd_stages(rd_stages)
  ) u_ram_rd_data_pipe (
    .clk(clk),
    .rst(rst),
    .tile_valid(tile_rd_valid),
    .tile_data(tile_rd_data),
    .rd_data_valid(rd_data_valid),
    .rd_data(rd_data)
  );

  // Every read answers after the full address and data pipeline
  read_latency_a: assert property (@(posedge clk) disable iff (rst)
    rd.valid |-> ##rd_latency rd_data_valid);

endmodule

/* tb/ram_flops_tb.sv */
// Testbench for the flop RAM with a reference model and checking assertions
module ram_flops_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // Reset, directed tests and 200 random cycles, with some margin
  localparam int test_cycles = 500;
  localparam int max_cycles = 4 * test_cycles;

  logic clk = 1'b0;
  logic rst;
  ram_pkg::wr_req_t wr;
  ram_pkg::rd_req_t rd;
  logic rd_data_valid;
  ram_pkg::data_t rd_data;

  // Reference memory and read predictions
  ram_pkg::data_t model [ram_pkg::depth];
  ram_pkg::data_t exp_q [$];
  ram_pkg::data_t exp_head;
  // Reads issued one and two cycles back
  logic issued_d1;
  logic issued_d2;

  int cycles = 0;
  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;

  ram_flops u_ram_flops (
    .clk(clk),
    .rst(rst),
    .wr(wr),
    .rd(rd),
    .rd_data_valid(rd_data_valid),
    .rd_data(rd_data)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Prediction comes before the write, so a same-cycle read sees old data
  // and the write shows up for reads from the next cycle on
  always @(posedge clk) begin
    if (rst) begin
      issued_d1 <= 1'b0;
      issued_d2 <= 1'b0;
    end else begin
      issued_d1 <= rd.valid;
      issued_d2 <= issued_d1;
      if (issued_d1) begin
        exp_head <= exp_q.pop_front();
      end
      if (rd.valid) begin
        exp_q.push_back(model[rd.addr]);
      end
      // Word-by-word merge of enabled bytes
      if (wr.valid) begin
        for (int w = 0; w < ram_pkg::num_words; w++) begin
          if (wr.word_en[w]) begin
            model[wr.addr][w*ram_pkg::word_width +: ram_pkg::word_width] =
              wr.data[w*ram_pkg::word_width +: ram_pkg::word_width];
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  missing_valid_a: assert property (@(posedge clk) disable iff (rst)
    issued_d2 |-> rd_data_valid)
    else begin
      $display("No rd_data_valid two cycles after a read, cycle %0d", cycles);
      errors++;
    end
  extra_valid_a: assert property (@(posedge clk) disable iff (rst)
    rd_data_valid |-> issued_d2)
    else begin
      $display("rd_data_valid set with no read two cycles before, cycle %0d", cycles);
      errors++;
    end
  data_match_a: assert property (@(posedge clk) disable iff (rst)
    (rd_data_valid && issued_d2) |-> (rd_data == exp_head))
    else begin
      $display("Error: rd_data expected %h actual %h", $sampled(exp_head), $sampled(rd_data));
      errors++;
    end

  // Cycle limit so a stuck run still ends
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, tests did not finish", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  // One cycle of requests, driven on the falling edge
  task automatic drive_cycle(input logic wv, input ram_pkg::addr_t wa,
                             input ram_pkg::data_t wd, input ram_pkg::word_en_t we,
                             input logic rv, input ram_pkg::addr_t ra);
    @(negedge clk);
    wr = '{valid: wv, addr: wa, data: wd, word_en: we};
    rd = '{valid: rv, addr: ra};
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0, '0, 1'b0, '0);
  endtask

  function automatic ram_pkg::addr_t rand_addr();
    return ram_pkg::addr_t'($urandom_range(ram_pkg::depth - 1, 0));
  endfunction

  // Drains the read pipe, then reports the test
  task automatic end_test(input string name, input int errors_before);
    idle_cycles(4);
    tests_run++;
    if (errors == errors_before) begin
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, errors - errors_before);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  initial begin
    int start;
    ram_pkg::addr_t a;
    void'($urandom(31));
    wr = '0;
    rd = '0;
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    // Quiet output before any read
    start = errors;
    idle_cycles(8);
    end_test("idle_after_reset", start);

    // Fill every entry, rewrite some, then back-to-back reads of all
    start = errors;
    for (int i = 0; i < ram_pkg::depth; i++) begin
      drive_cycle(1'b1, ram_pkg::addr_t'(i), $urandom(), '1, 1'b0, '0);
    end
    for (int i = 0; i < 24; i++) begin
      drive_cycle(1'b1, rand_addr(), $urandom(), '1, 1'b0, '0);
    end
    for (int i = 0; i < ram_pkg::depth; i++) begin
      drive_cycle(1'b0, '0, '0, '0, 1'b1, ram_pkg::addr_t'(ram_pkg::depth - 1 - i));
    end
    end_test("full_writes", start);

    // Random byte enables, each checked by a read on the next cycle
    start = errors;
    for (int i = 0; i < 40; i++) begin
      a = rand_addr();
      drive_cycle(1'b1, a, $urandom(), ram_pkg::word_en_t'($urandom_range(15, 0)), 1'b0, '0);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
    end
    end_test("partial_writes", start);

    // Same-cycle read sees old data, next cycle sees new
    start = errors;
    for (int i = 0; i < 4; i++) begin
      a = (i < 2) ? ram_pkg::addr_t'(3 + i) : ram_pkg::addr_t'(15 + i);
      drive_cycle(1'b1, a, $urandom(), '1, 1'b1, a);
      drive_cycle(1'b0, '0, '0, '0, 1'b1, a);
    end
    end_test("read_during_write", start);

    // Independent random writes and reads, all entries already written
    start = errors;
    for (int i = 0; i < 200; i++) begin
      drive_cycle($urandom_range(1, 0) == 1, rand_addr(), $urandom(),
                  ram_pkg::word_en_t'($urandom_range(15, 0)),
                  $urandom_range(1, 0) == 1, rand_addr());
    end
    end_test("random_traffic", start);

    $display("Tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* ram_flops.f */
hw/ram_pkg.sv
hw/ram_addr_decoder.sv
hw/ram_flops_tile.sv
hw/ram_rd_data_pipe.sv
hw/ram_flops.sv
tb/ram_flops_tb.sv

/* Makefile */
# Verilator lint, simulation and cleanup for the flop RAM
TOP := ram_flops_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f ram_flops.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f ram_flops.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf obj_dir
